/* verilog/soc_bus_pkg.sv */
package soc_bus_pkg;

    // Bus widths, matching the CPU side
    localparam int addr_width = 64;
    localparam int data_width = 64;

    // 8 KB of 32-bit words
    localparam int mem_words = 2048;
    localparam int mem_index_width = 11;
    localparam logic [addr_width-1:0] mem_limit = 64'h2000;

    // Memory-mapped I/O registers
    localparam logic [addr_width-1:0] uart_addr = 64'h2000;
    localparam logic [addr_width-1:0] key_addr = 64'h2008;

    // UART transmit queue
    localparam int uart_depth = 4;
    localparam int uart_ptr_width = $clog2(uart_depth);
    localparam int uart_count_width = $clog2(uart_depth + 1);

    // Vector raised on a key press
    localparam logic [3:0] key_irq_vector = 4'd1;

    // Which target answered a request
    localparam logic [1:0] tgt_none = 2'd0;
    localparam logic [1:0] tgt_mem = 2'd1;
    localparam logic [1:0] tgt_io = 2'd2;

    // One memory word, seen whole or as bytes
    typedef union packed {
        logic [31:0] word;
        logic [3:0][7:0] bytes;
    } mem_word_u;

endpackage

/* verilog/cache_memory.sv */
module cache_memory (
    input  logic                                    CLOCK_50,
    // Data port, read or write
    input  logic                                    mem_en,
    input  logic                                    mem_write,
    input  logic [soc_bus_pkg::mem_index_width-1:0] mem_index,
    input  logic [31:0]                             mem_wdata,
    output logic [31:0]                             mem_rdata,
    // Fetch port, read only
    input  logic [soc_bus_pkg::mem_index_width-1:0] fetch_index,
    output logic [31:0]                             fetch_instr
);
    import soc_bus_pkg::*;

    // Block RAM, 2048 x 32
    logic [31:0] ram [mem_words];

    logic [31:0] data_q;
    mem_word_u fetch_q;
    mem_word_u fetch_swapped;

    // Data port keeps its last read word while idle
    always_ff @(posedge CLOCK_50) begin
        if (mem_en) begin
            if (mem_write) begin
                ram[mem_index] <= mem_wdata;
            end else begin
                data_q <= ram[mem_index];
            end
        end
    end

    assign mem_rdata = data_q;

    // Fetch port reads every cycle
    always_ff @(posedge CLOCK_50) begin
        fetch_q.word <= ram[fetch_index];
    end

    // Stored little-endian, instruction wants the other order
    always_comb begin
        fetch_swapped.word = '0;
        for (int i = 0; i < 4; i++) begin
            fetch_swapped.bytes[i] = fetch_q.bytes[3-i];
        end
    end

    assign fetch_instr = fetch_swapped.word;

endmodule

/* verilog/io_block.sv */
module io_block (
    input  logic                               CLOCK_50,
    input  logic                               KEY0,
    // Bus side
    input  logic                               io_en,
    input  logic                               io_write,
    input  logic                               io_is_key,
    input  logic [soc_bus_pkg::data_width-1:0] io_wdata,
    output logic [soc_bus_pkg::data_width-1:0] io_rdata,
    // Decoded keyboard stream
    input  logic                               key_valid,
    input  logic [7:0]                         key_code,
    output logic                               key_ready,
    // Interrupt
    output logic [3:0]                         irq_vector,
    input  logic                               irq_ack,
    // UART transmit stream
    output logic                               uart_valid,
    output logic [7:0]                         uart_data,
    input  logic                               uart_ready
);
    import soc_bus_pkg::*;

    logic [7:0] key_q;
    logic [7:0] uart_queue [uart_depth];
    logic [uart_ptr_width-1:0] wr_ptr;
    logic [uart_ptr_width-1:0] rd_ptr;
    logic [uart_count_width-1:0] uart_count;
    logic uart_push;
    logic uart_pop;

    // Keyboard is never stalled
    assign key_ready = 1'b1;

    // Last key code and one-shot interrupt
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_q <= '0;
            irq_vector <= '0;
        end else begin
            if (irq_vector != '0 && irq_ack) begin
                irq_vector <= '0;
            end
            if (key_valid && key_ready) begin
                key_q <= key_code;
                // A zero code only updates the register
                if (key_code != 8'd0) begin
                    irq_vector <= key_irq_vector;
                end
            end
        end
    end

    // Full queue drops the byte
    assign uart_push = io_en && io_write && !io_is_key &&
                       (uart_count != uart_count_width'(uart_depth));
    assign uart_pop = uart_valid && uart_ready;

    assign uart_valid = (uart_count != '0);
    assign uart_data = uart_queue[rd_ptr];

    always_ff @(posedge CLOCK_50) begin
        if (uart_push) begin
            uart_queue[wr_ptr] <= io_wdata[7:0];
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            uart_count <= '0;
        end else begin
            if (uart_push) begin
                wr_ptr <= (wr_ptr == uart_ptr_width'(uart_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (uart_pop) begin
                rd_ptr <= (rd_ptr == uart_ptr_width'(uart_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({uart_push, uart_pop})
                2'b10: uart_count <= uart_count + 1'b1;
                2'b01: uart_count <= uart_count - 1'b1;
                default: uart_count <= uart_count;
            endcase
        end
    end

    // Read data: key code, or UART fill count
    always_ff @(posedge CLOCK_50) begin
        if (io_en) begin
            if (io_is_key) begin
                io_rdata <= data_width'(key_q);
            end else begin
                io_rdata <= data_width'(uart_count);
            end
        end
    end

endmodule

/* verilog/bus_responder.sv */
module bus_responder (
    input  logic                                    CLOCK_50,
    input  logic                                    KEY0,
    // Request side
    input  logic                                    req_valid,
    input  logic                                    req_write,
    output logic                                    req_ready,
    input  logic [soc_bus_pkg::addr_width-1:0]      req_addr,
    input  logic [soc_bus_pkg::data_width-1:0]      req_wdata,
    // Response side
    output logic                                    resp_valid,
    output logic [soc_bus_pkg::data_width-1:0]      resp_rdata,
    input  logic                                    resp_ready,
    // Memory target
    output logic                                    mem_en,
    output logic                                    mem_write,
    output logic [soc_bus_pkg::mem_index_width-1:0] mem_index,
    output logic [31:0]                             mem_wdata,
    input  logic [31:0]                             mem_rdata,
    // I/O target
    output logic                                    io_en,
    output logic                                    io_write,
    output logic                                    io_is_key,
    output logic [soc_bus_pkg::data_width-1:0]      io_wdata,
    input  logic [soc_bus_pkg::data_width-1:0]      io_rdata
);
    import soc_bus_pkg::*;

    logic accept;
    logic hit_io;
    logic hit_mem;
    logic [1:0] sel_q;
    logic wr_q;
    logic first_q;
    logic [data_width-1:0] merged;
    logic [data_width-1:0] rdata_q;

    // Only one request in flight
    assign req_ready = !resp_valid || resp_ready;
    assign accept = req_valid && req_ready;

    assign hit_io = (req_addr == key_addr) || (req_addr == uart_addr);
    assign hit_mem = (req_addr < mem_limit);

    assign mem_en = accept && hit_mem;
    assign mem_write = req_write;
    assign mem_index = req_addr[12:2];
    assign mem_wdata = req_wdata[31:0];

    assign io_en = accept && hit_io;
    assign io_write = req_write;
    assign io_is_key = (req_addr == key_addr);
    assign io_wdata = req_wdata;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            resp_valid <= 1'b0;
            first_q <= 1'b0;
            sel_q <= tgt_none;
            wr_q <= 1'b0;
        end else begin
            first_q <= accept;
            if (accept) begin
                resp_valid <= 1'b1;
                wr_q <= req_write;
                sel_q <= hit_io ? tgt_io : (hit_mem ? tgt_mem : tgt_none);
            end else if (resp_ready) begin
                resp_valid <= 1'b0;
            end
        end
    end

    // Writes and unmapped reads answer zero
    always_comb begin
        merged = '0;
        if (!wr_q) begin
            case (sel_q)
                tgt_mem: merged = data_width'(mem_rdata);
                tgt_io: merged = io_rdata;
                default: merged = '0;
            endcase
        end
    end

    // Hold the merged word while the master stalls
    always_ff @(posedge CLOCK_50) begin
        if (first_q) begin
            rdata_q <= merged;
        end
    end

    assign resp_rdata = first_q ? merged : rdata_q;

endmodule

/* verilog/soc_bus.sv */
module soc_bus (
    input  logic                               CLOCK_50,
    input  logic                               KEY0,
    // Data request
    input  logic                               req_valid,
    output logic                               req_ready,
    input  logic                               req_write,
    input  logic [soc_bus_pkg::addr_width-1:0] req_addr,
    input  logic [soc_bus_pkg::data_width-1:0] req_wdata,
    // Data response
    output logic                               resp_valid,
    input  logic                               resp_ready,
    output logic [soc_bus_pkg::data_width-1:0] resp_rdata,
    // Instruction fetch
    input  logic [soc_bus_pkg::addr_width-1:0] fetch_addr,
    output logic [31:0]                        fetch_instr,
    // Keyboard
    input  logic                               key_valid,
    output logic                               key_ready,
    input  logic [7:0]                         key_code,
    // Interrupt
    output logic [3:0]                         irq_vector,
    input  logic                               irq_ack,
    // UART
    output logic                               uart_valid,
    input  logic                               uart_ready,
    output logic [7:0]                         uart_data
);
    import soc_bus_pkg::*;

    logic mem_en;
    logic mem_write;
    logic [mem_index_width-1:0] mem_index;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic [mem_index_width-1:0] fetch_index;
    logic io_en;
    logic io_write;
    logic io_is_key;
    logic [data_width-1:0] io_wdata;
    logic [data_width-1:0] io_rdata;

    // Word index of the fetch address
    assign fetch_index = fetch_addr[12:2];

    bus_responder bus_responder_inst (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_ready  (req_ready),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .resp_ready (resp_ready),
        .mem_en     (mem_en),
        .mem_write  (mem_write),
        .mem_index  (mem_index),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .io_en      (io_en),
        .io_write   (io_write),
        .io_is_key  (io_is_key),
        .io_wdata   (io_wdata),
        .io_rdata   (io_rdata)
    );

    cache_memory cache_memory_inst (
        .CLOCK_50    (CLOCK_50),
        .mem_en      (mem_en),
        .mem_write   (mem_write),
        .mem_index   (mem_index),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .fetch_index (fetch_index),
        .fetch_instr (fetch_instr)
    );

    io_block io_block_inst (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .io_en      (io_en),
        .io_write   (io_write),
        .io_is_key  (io_is_key),
        .io_wdata   (io_wdata),
        .io_rdata   (io_rdata),
        .key_valid  (key_valid),
        .key_code   (key_code),
        .key_ready  (key_ready),
        .irq_vector (irq_vector),
        .irq_ack    (irq_ack),
        .uart_valid (uart_valid),
        .uart_data  (uart_data),
        .uart_ready (uart_ready)
    );

endmodule

/* dv/tb_checker.sv */
module tb_checker (
    input logic        req_ready,
    input logic        resp_valid,
    input logic [63:0] resp_rdata,
    input logic [31:0] fetch_instr,
    input logic        key_ready,
    input logic [3:0]  irq_vector,
    input logic        uart_valid,
    input logic [7:0]  uart_data
);
    // Memory words written during the run
    logic [31:0] ref_mem [2048];
    logic [63:0] held_rdata;
    int pass_count = 0;
    int fail_count = 0;
    int test_errors = 0;
    int test_id = 0;
    string test_name;

    task automatic start_test(input int id, input string name);
        test_id = id;
        test_name = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            pass_count++;
            $display("Test %0d %s: ok", test_id, test_name);
        end else begin
            fail_count++;
            $display("Test %0d %s: %0d error(s)", test_id, test_name, test_errors);
        end
    endtask

    task automatic compare(input string sig, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            test_errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, sig, exp, act);
        end
    endtask

    task automatic report_missing(input string what);
        test_errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // Only the 8 KB region is memory
    task automatic note_write(input logic [63:0] addr, input logic [63:0] data);
        if (addr < 64'h2000) begin
            ref_mem[addr[12:2]] = data[31:0];
        end
    endtask

    task automatic check_response(input logic write, input logic [63:0] addr,
                                  input logic [63:0] row_exp);
        logic [63:0] exp;
        if (write) begin
            exp = '0;
        end else if (addr < 64'h2000) begin
            exp = {32'd0, ref_mem[addr[12:2]]};
        end else begin
            exp = row_exp;
        end
        compare("resp_valid", 64'd1, {63'd0, resp_valid});
        compare("resp_rdata", exp, resp_rdata);
        held_rdata = resp_rdata;
    endtask

    task automatic check_hold();
        compare("resp_valid", 64'd1, {63'd0, resp_valid});
        compare("resp_rdata", held_rdata, resp_rdata);
        compare("req_ready", 64'd0, {63'd0, req_ready});
    endtask

    // Instruction comes out with its bytes in reverse order
    task automatic check_fetch(input logic [63:0] addr);
        logic [31:0] w;
        w = ref_mem[addr[12:2]];
        compare("fetch_instr", {32'd0, w[7:0], w[15:8], w[23:16], w[31:24]},
                {32'd0, fetch_instr});
    endtask

    task automatic check_key_ready();
        compare("key_ready", 64'd1, {63'd0, key_ready});
    endtask

    task automatic check_irq(input logic [3:0] exp);
        compare("irq_vector", {60'd0, exp}, {60'd0, irq_vector});
    endtask

    task automatic check_uart(input logic [7:0] exp);
        if (!uart_valid) begin
            report_missing("no UART byte within 20 cycles");
        end else begin
            compare("uart_data", {56'd0, exp}, {56'd0, uart_data});
        end
    endtask

    task automatic report_counts();
        $display("Tests: %0d ok, %0d with errors", pass_count, fail_count);
    endtask

endmodule

/* dv/tb_soc_bus.sv */
module tb_soc_bus;
    localparam int max_rows = 40;
    localparam int op_write = 0;
    localparam int op_read = 1;
    localparam int op_fetch = 2;
    localparam int op_key = 3;
    localparam int op_ack = 4;
    localparam int op_drain = 5;
    localparam int op_stall = 6;

    logic CLOCK_50 = 1'b0;
    logic KEY0 = 1'b0;
    logic req_valid = 1'b0;
    logic req_write = 1'b0;
    logic [63:0] req_addr = '0;
    logic [63:0] req_wdata = '0;
    logic resp_ready = 1'b1;
    logic [63:0] fetch_addr = '0;
    logic key_valid = 1'b0;
    logic [7:0] key_code = '0;
    logic irq_ack = 1'b0;
    logic uart_ready = 1'b0;
    logic req_ready;
    logic resp_valid;
    logic key_ready;
    logic uart_valid;
    logic [63:0] resp_rdata;
    logic [31:0] fetch_instr;
    logic [3:0] irq_vector;
    logic [7:0] uart_data;

    // Stimulus table: operation, address, data, expected value, resp_ready hold-off
    int row_op [max_rows];
    logic [63:0] row_addr [max_rows];
    logic [63:0] row_data [max_rows];
    logic [63:0] row_exp [max_rows];
    int row_hold [max_rows];
    int row_count = 0;
    logic table_ready = 1'b0;
    logic [31:0] lcg_state = 32'hce03;

    always #2 CLOCK_50 = ~CLOCK_50;

    soc_bus soc_bus_inst (.*);

    tb_checker tb_checker_inst (
        .req_ready(req_ready), .resp_valid(resp_valid),
        .resp_rdata(resp_rdata), .fetch_instr(fetch_instr), .key_ready(key_ready),
        .irq_vector(irq_vector), .uart_valid(uart_valid), .uart_data(uart_data)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic add_row(input int op, input logic [63:0] addr, input logic [63:0] data,
                           input logic [63:0] exp, input int hold);
        row_op[row_count] = op;
        row_addr[row_count] = addr;
        row_data[row_count] = data;
        row_exp[row_count] = exp;
        row_hold[row_count] = hold;
        row_count++;
    endtask

    // Starts and ends one time unit after a rising edge
    task automatic run_request(input logic write, input logic [63:0] addr,
                               input logic [63:0] wdata, input logic [63:0] exp,
                               input int hold);
        int n;
        n = 0;
        req_valid = 1'b1;
        req_write = write;
        req_addr = addr;
        req_wdata = wdata;
        resp_ready = (hold == 0);
        @(negedge CLOCK_50);
        while (!req_ready && n < 20) begin
            n++;
            @(negedge CLOCK_50);
        end
        if (!req_ready) begin
            tb_checker_inst.report_missing("req_ready stayed low for 20 cycles");
        end
        @(posedge CLOCK_50);
        #1 req_valid = 1'b0;
        if (write) begin
            tb_checker_inst.note_write(addr, wdata);
        end
        @(negedge CLOCK_50);
        tb_checker_inst.check_response(write, addr, exp);
        repeat (hold) begin
            @(negedge CLOCK_50);
            tb_checker_inst.check_hold();
        end
        if (hold > 0) begin
            @(posedge CLOCK_50);
            #1 resp_ready = 1'b1;
        end
        @(posedge CLOCK_50);
        #1;
    endtask

    task automatic run_row(input int i);
        logic [63:0] wdata;
        logic [63:0] prev_addr;
        int n;
        case (row_op[i])
            op_write, op_read, op_stall: begin
                wdata = (row_addr[i] < 64'h2000 || row_addr[i] > 64'h2008) ?
                        {lcg_next(), lcg_next()} : row_data[i];
                run_request(row_op[i] == op_write, row_addr[i], wdata, row_exp[i],
                            row_hold[i]);
            end
            op_fetch: begin
                prev_addr = fetch_addr;
                fetch_addr = row_addr[i];
                // Old word stays until the next edge
                @(negedge CLOCK_50);
                tb_checker_inst.check_fetch(prev_addr);
                @(posedge CLOCK_50);
                @(negedge CLOCK_50);
                tb_checker_inst.check_fetch(row_addr[i]);
                @(posedge CLOCK_50);
                #1;
            end
            op_key, op_ack: begin
                key_valid = (row_op[i] == op_key);
                key_code = row_data[i][7:0];
                irq_ack = (row_op[i] == op_ack);
                @(negedge CLOCK_50);
                tb_checker_inst.check_key_ready();
                @(posedge CLOCK_50);
                #1 key_valid = 1'b0;
                irq_ack = 1'b0;
                @(negedge CLOCK_50);
                tb_checker_inst.check_irq(row_exp[i][3:0]);
                @(posedge CLOCK_50);
                #1;
            end
            default: begin
                n = 0;
                @(negedge CLOCK_50);
                while (!uart_valid && n < 20) begin
                    n++;
                    @(negedge CLOCK_50);
                end
                tb_checker_inst.check_uart(row_exp[i][7:0]);
                @(posedge CLOCK_50);
                #1 uart_ready = 1'b1;
                @(posedge CLOCK_50);
                #1 uart_ready = 1'b0;
            end
        endcase
    endtask

    initial begin
        add_row(op_write, 64'h0000, 0, 0, 0);
        add_row(op_write, 64'h0004, 0, 0, 0);
        add_row(op_write, 64'h0100, 0, 0, 0);
        add_row(op_write, 64'h1ffc, 0, 0, 0);
        add_row(op_read, 64'h0000, 0, 0, 0);
        add_row(op_read, 64'h0004, 0, 0, 0);
        add_row(op_read, 64'h0100, 0, 0, 0);
        add_row(op_read, 64'h1ffc, 0, 0, 0);
        add_row(op_fetch, 64'h0004, 0, 0, 0);
        add_row(op_fetch, 64'h1ffc, 0, 0, 0);
        add_row(op_write, 64'h0040, 0, 0, 0);
        add_row(op_stall, 64'h0040, 0, 0, 5);
        add_row(op_read, 64'h0004, 0, 0, 0);
        add_row(op_key, 0, 8'h5a, 1, 0);
        add_row(op_read, 64'h2008, 0, 8'h5a, 0);
        add_row(op_ack, 0, 0, 0, 0);
        add_row(op_key, 0, 8'h00, 0, 0);
        add_row(op_read, 64'h2008, 0, 0, 0);
        // Five bytes into a four-entry queue
        add_row(op_write, 64'h2000, 8'h11, 0, 0);
        add_row(op_write, 64'h2000, 8'h22, 0, 0);
        add_row(op_write, 64'h2000, 8'h33, 0, 0);
        add_row(op_write, 64'h2000, 8'h44, 0, 0);
        add_row(op_write, 64'h2000, 8'h55, 0, 0);
        add_row(op_read, 64'h2000, 0, 4, 0);
        add_row(op_drain, 0, 0, 8'h11, 0);
        add_row(op_drain, 0, 0, 8'h22, 0);
        add_row(op_drain, 0, 0, 8'h33, 0);
        add_row(op_drain, 0, 0, 8'h44, 0);
        add_row(op_read, 64'h2000, 0, 0, 0);
        // Word index of this address aliases word 0
        add_row(op_write, 64'h10000, 0, 0, 0);
        add_row(op_read, 64'h10000, 0, 0, 0);
        add_row(op_read, 64'h0000, 0, 0, 0);
        table_ready = 1'b1;
        repeat (10) @(posedge CLOCK_50);
        #1 KEY0 = 1'b1;
        @(posedge CLOCK_50);
        #1;
        for (int i = 0; i < row_count; i++) begin
            tb_checker_inst.start_test(i, $sformatf("op %0d addr %h", row_op[i], row_addr[i]));
            run_row(i);
            tb_checker_inst.end_test();
        end
        tb_checker_inst.report_counts();
        if (tb_checker_inst.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog, 30 cycles per table row
    initial begin
        wait (table_ready);
        repeat (10 + row_count * 30) @(posedge CLOCK_50);
        $display("Watchdog expired before the table finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* list.f */
verilog/soc_bus_pkg.sv
verilog/cache_memory.sv
verilog/io_block.sv
verilog/bus_responder.sv
verilog/soc_bus.sv
dv/tb_checker.sv
dv/tb_soc_bus.sv

/* Bender.yml */
package:
  name: soc_bus

sources:
  # Package first, then the blocks, then the top level
  - files:
      - verilog/soc_bus_pkg.sv
      - verilog/cache_memory.sv
      - verilog/io_block.sv
      - verilog/bus_responder.sv
      - verilog/soc_bus.sv
  - target: test
    files:
      - dv/tb_checker.sv
      - dv/tb_soc_bus.sv
